// File: common/fp_log_pkg.sv
package fp_log_pkg;

    // fp16 field layout
    localparam int unsigned FP_WIDTH  = 16;
    localparam int unsigned EXP_WIDTH = 5;
    localparam int unsigned MAN_WIDTH = 10;
    localparam int unsigned EXP_BIAS  = 15;

    // both log tables have 32 entries
    localparam int unsigned LUT_INDEX_WIDTH = 5;

    localparam int unsigned SIGN_BIT = FP_WIDTH - 1;
    localparam int unsigned EXP_LSB  = MAN_WIDTH;    // exponent sits right above mantissa

    // top mantissa bits feed the mantissa table
    localparam int unsigned MAN_INDEX_LSB = MAN_WIDTH - LUT_INDEX_WIDTH;

    // all-ones exponent, inf or nan
    localparam logic [EXP_WIDTH-1:0] EXP_MAX = '1;

    localparam logic [FP_WIDTH-1:0] FP_NEG_INF = 16'hFC00;
    localparam logic [FP_WIDTH-1:0] FP_POS_INF = 16'h7C00;
    localparam logic [FP_WIDTH-1:0] FP_QNAN    = 16'h7E00;   // canonical quiet nan

    // input class decided in stage 1 of fp16_log
    //   CLASS_ZERO      zero or subnormal (flushed)
    //   CLASS_NORMAL    positive normal, goes through the tables
    //   CLASS_POS_INF   +inf
    //   CLASS_NAN       any nan, either sign
    //   CLASS_NEGATIVE  negative nonzero, including -inf
    typedef enum logic [2:0] {
        CLASS_ZERO,
        CLASS_NORMAL,
        CLASS_POS_INF,
        CLASS_NAN,
        CLASS_NEGATIVE
    } fp_class_e;

endpackage

// File: hw/exponent_log_lut.sv
`timescale 1ns/1ps

// (e - bias) * ln2 for every biased exponent e
module exponent_log_lut (
    input  logic [fp_log_pkg::EXP_WIDTH-1:0] exp_field,
    output logic [fp_log_pkg::FP_WIDTH-1:0]  log_value
);

    always_comb begin
        case (exp_field)
            5'd0:  log_value = fp_log_pkg::FP_NEG_INF;   // zero, subnormal
            5'd1:  log_value = 16'hC8DA;   // -14 ln2
            5'd2:  log_value = 16'hC881;
            5'd3:  log_value = 16'hC829;
            5'd4:  log_value = 16'hC7A0;
            5'd5:  log_value = 16'hC6EE;
            5'd6:  log_value = 16'hC63D;
            5'd7:  log_value = 16'hC58C;
            5'd8:  log_value = 16'hC4DA;
            5'd9:  log_value = 16'hC429;
            5'd10: log_value = 16'hC2EE;
            5'd11: log_value = 16'hC18C;
            5'd12: log_value = 16'hC029;
            5'd13: log_value = 16'hBD8C;
            5'd14: log_value = 16'hB98C;   // -ln2
            5'(fp_log_pkg::EXP_BIAS): log_value = '0;   // 1.0 .. 2.0, exactly zero
            5'd16: log_value = 16'h398C;   // +ln2
            5'd17: log_value = 16'h3D8C;
            5'd18: log_value = 16'h4029;
            5'd19: log_value = 16'h418C;
            5'd20: log_value = 16'h42EE;
            5'd21: log_value = 16'h4429;
            5'd22: log_value = 16'h44DA;
            5'd23: log_value = 16'h458C;
            5'd24: log_value = 16'h463D;
            5'd25: log_value = 16'h46EE;
            5'd26: log_value = 16'h47A0;
            5'd27: log_value = 16'h4829;
            5'd28: log_value = 16'h4881;
            5'd29: log_value = 16'h48DA;
            5'd30: log_value = 16'h4933;   // +15 ln2
            default: log_value = fp_log_pkg::FP_POS_INF;   // e = 31
        endcase
    end

endmodule

// File: hw/mantissa_log_lut.sv
`timescale 1ns/1ps

// ln(1 + i/32) per mantissa segment, no interpolation
module mantissa_log_lut (
    input  logic [fp_log_pkg::LUT_INDEX_WIDTH-1:0] man_index,
    output logic [fp_log_pkg::FP_WIDTH-1:0]        log_value
);

    always_comb begin
        case (man_index)
            5'd0:  log_value = 16'h0000;   // exact zero, powers of two
            5'd1:  log_value = 16'h27E1;
            5'd2:  log_value = 16'h2BC3;
            5'd3:  log_value = 16'h2DBC;
            5'd4:  log_value = 16'h2F8A;   // ln 1.125
            5'd5:  log_value = 16'h30A5;
            5'd6:  log_value = 16'h3180;
            5'd7:  log_value = 16'h3255;
            5'd8:  log_value = 16'h3324;   // ln 1.25
            5'd9:  log_value = 16'h33EE;
            5'd10: log_value = 16'h345A;
            5'd11: log_value = 16'h34BA;
            5'd12: log_value = 16'h3518;   // ln 1.375
            5'd13: log_value = 16'h3574;
            5'd14: log_value = 16'h35CE;
            5'd15: log_value = 16'h3627;
            5'd16: log_value = 16'h367D;   // ln 1.5
            5'd17: log_value = 16'h36D1;
            5'd18: log_value = 16'h3724;
            5'd19: log_value = 16'h3775;
            5'd20: log_value = 16'h37C5;   // ln 1.625
            5'd21: log_value = 16'h3809;
            5'd22: log_value = 16'h3830;
            5'd23: log_value = 16'h3855;
            5'd24: log_value = 16'h387A;   // ln 1.75
            5'd25: log_value = 16'h389E;
            5'd26: log_value = 16'h38C2;
            5'd27: log_value = 16'h38E5;
            5'd28: log_value = 16'h3907;   // ln 1.875
            5'd29: log_value = 16'h3929;
            5'd30: log_value = 16'h394B;
            default: log_value = 16'h396B;   // i = 31, ln(63/32)
        endcase
    end

    // all entries are positive and below ln2,
    // so the adder never sees a carry into a new binade from this side alone

endmodule

// File: fp16_adder/fp16_add.sv
`timescale 1ns/1ps

// two-stage fp16 adder, round to nearest even
// stage a: unpack, order by magnitude, align with guard/round/sticky
// stage b: add or subtract, normalize, round, pack
module fp16_add (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            valid_in,
    input  logic [fp_log_pkg::FP_WIDTH-1:0] a,
    input  logic [fp_log_pkg::FP_WIDTH-1:0] b,
    output logic                            valid_out,
    output logic [fp_log_pkg::FP_WIDTH-1:0] sum
);

    localparam int FW  = fp_log_pkg::FP_WIDTH;
    localparam int EW  = fp_log_pkg::EXP_WIDTH;
    localparam int MW  = fp_log_pkg::MAN_WIDTH;
    localparam int SW  = MW + 1;   // significand incl. hidden bit
    localparam int XW  = SW + 3;   // plus guard, round, sticky
    localparam int XEW = EW + 2;   // signed exponent headroom

    // stage a, combinational
    logic          a_sign;
    logic          b_sign;
    logic [EW-1:0] a_exp;
    logic [EW-1:0] b_exp;
    logic [SW-1:0] a_sig;
    logic [SW-1:0] b_sig;
    logic          a_inf;
    logic          b_inf;
    logic          swap;
    logic [EW-1:0] exp_diff;
    logic [EW-1:0] shamt;
    logic [SW-1:0] big_sig;
    logic [SW-1:0] small_sig;
    logic [2*XW-1:0] shift_buf;
    logic [XW-1:0] small_aligned;

    // stage a registers
    logic          sa_valid;
    logic          sa_sign;
    logic          sa_sub;
    logic [EW-1:0] sa_exp;
    logic [XW-1:0] sa_big;
    logic [XW-1:0] sa_small;
    logic          sa_inf;
    logic [FW-1:0] sa_inf_value;

    // stage b, combinational
    logic [XW:0]          raw;
    logic [3:0]           lz;
    logic [XW-1:0]        norm;
    logic signed [XEW-1:0] exp_norm;
    logic                 round_up;
    logic [SW:0]          rounded;
    logic signed [XEW-1:0] exp_final;
    logic [MW-1:0]        man_final;
    logic [FW-1:0]        result;

    function automatic logic [3:0] count_lz(input logic [XW-1:0] v);
        logic [3:0] n;
        n = 4'(XW);
        for (int i = 0; i < XW; i++) begin
            if (v[i]) begin
                n = 4'(XW - 1 - i);   // highest set bit wins
            end
        end
        return n;
    endfunction

    assign a_sign = a[fp_log_pkg::SIGN_BIT];
    assign b_sign = b[fp_log_pkg::SIGN_BIT];
    assign a_exp  = a[fp_log_pkg::EXP_LSB +: EW];
    assign b_exp  = b[fp_log_pkg::EXP_LSB +: EW];
    assign a_inf  = (a_exp == fp_log_pkg::EXP_MAX);
    assign b_inf  = (b_exp == fp_log_pkg::EXP_MAX);

    // subnormal operands flush to zero
    assign a_sig = (a_exp != '0) ? {1'b1, a[MW-1:0]} : '0;
    assign b_sig = (b_exp != '0) ? {1'b1, b[MW-1:0]} : '0;

    always_comb begin
        swap      = {b_exp, b_sig} > {a_exp, a_sig};
        big_sig   = swap ? b_sig : a_sig;
        small_sig = swap ? a_sig : b_sig;
        exp_diff  = swap ? (b_exp - a_exp) : (a_exp - b_exp);
        shamt     = (exp_diff > EW'(XW)) ? EW'(XW) : exp_diff;   // beyond XW only sticky is left
        shift_buf = {small_sig, 3'b000, {XW{1'b0}}} >> shamt;
        small_aligned = {shift_buf[2*XW-1:XW+1], shift_buf[XW] | (|shift_buf[XW-1:0])};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sa_valid <= 1'b0;
        end else begin
            sa_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        sa_sign  <= swap ? b_sign : a_sign;   // result takes the larger magnitude's sign
        sa_sub   <= a_sign ^ b_sign;
        sa_exp   <= swap ? b_exp : a_exp;
        sa_big   <= {big_sig, 3'b000};
        sa_small <= small_aligned;
        sa_inf   <= a_inf | b_inf;
        sa_inf_value <= a_inf ? {a_sign, fp_log_pkg::EXP_MAX, {MW{1'b0}}}
                              : {b_sign, fp_log_pkg::EXP_MAX, {MW{1'b0}}};
    end

    always_comb begin
        raw = sa_sub ? ({1'b0, sa_big} - {1'b0, sa_small})
                     : ({1'b0, sa_big} + {1'b0, sa_small});
        lz  = count_lz(raw[XW-1:0]);

        if (raw[XW]) begin
            // carry out, shift right one and keep the sticky
            norm     = {raw[XW:2], raw[1] | raw[0]};
            exp_norm = $signed({2'b00, sa_exp}) + XEW'(1);
        end else begin
            norm     = raw[XW-1:0] << lz;
            exp_norm = $signed({2'b00, sa_exp}) - $signed({3'b000, lz});
        end

        // nearest even on guard with round|sticky|lsb
        round_up  = norm[2] & (norm[1] | norm[0] | norm[3]);
        rounded   = {1'b0, norm[XW-1:3]} + (SW+1)'(round_up);
        man_final = rounded[SW] ? rounded[MW:1] : rounded[MW-1:0];
        exp_final = rounded[SW] ? (exp_norm + XEW'(1)) : exp_norm;

        if (sa_inf) begin
            result = sa_inf_value;
        end else if (raw == '0) begin
            result = '0;   // exact cancellation gives +0
        end else if (exp_final <= XEW'(0)) begin
            result = {sa_sign, {(FW-1){1'b0}}};   // would be subnormal, flush
        end else if (exp_final >= $signed({2'b00, fp_log_pkg::EXP_MAX})) begin
            result = {sa_sign, fp_log_pkg::EXP_MAX, {MW{1'b0}}};
        end else begin
            result = {sa_sign, exp_final[EW-1:0], man_final};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= sa_valid;
        end
    end

    always_ff @(posedge clk) begin
        sum <= result;
    end

    valid_out_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(valid_out))
        else $error("fp16_add: valid_out unknown after reset");

endmodule

// File: hw/fp16_log.sv
`timescale 1ns/1ps

// ln(x) for fp16: table(exponent) + table(top mantissa bits)
module fp16_log (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            in_valid,
    input  logic [fp_log_pkg::FP_WIDTH-1:0] in_data,
    output logic                            out_valid,
    output logic [fp_log_pkg::FP_WIDTH-1:0] out_data
);

    localparam int FW = fp_log_pkg::FP_WIDTH;
    localparam int EW = fp_log_pkg::EXP_WIDTH;
    localparam int MW = fp_log_pkg::MAN_WIDTH;
    localparam int LW = fp_log_pkg::LUT_INDEX_WIDTH;

    logic          in_sign;
    logic [EW-1:0] in_exp;
    logic [MW-1:0] in_man;
    fp_log_pkg::fp_class_e in_class;
    logic [EW-1:0] exp_index;
    logic [LW-1:0] man_index;
    logic [FW-1:0] exp_log;
    logic [FW-1:0] man_log;

    // stage 1 registers
    logic          s1_valid;
    fp_log_pkg::fp_class_e s1_class;
    logic [FW-1:0] s1_exp_log;
    logic [FW-1:0] s1_man_log;

    // class rides beside the adder
    fp_log_pkg::fp_class_e cls_d1;
    fp_log_pkg::fp_class_e cls_d2;

    logic          add_valid;
    logic [FW-1:0] add_sum;
    logic [FW-1:0] out_next;

    assign in_sign = in_data[fp_log_pkg::SIGN_BIT];
    assign in_exp  = in_data[fp_log_pkg::EXP_LSB +: EW];
    assign in_man  = in_data[MW-1:0];

    always_comb begin
        if (in_exp == '0) begin
            in_class = fp_log_pkg::CLASS_ZERO;   // either sign, subnormals too
        end else if (in_exp == fp_log_pkg::EXP_MAX && in_man != '0) begin
            in_class = fp_log_pkg::CLASS_NAN;
        end else if (in_sign) begin
            in_class = fp_log_pkg::CLASS_NEGATIVE;
        end else if (in_exp == fp_log_pkg::EXP_MAX) begin
            in_class = fp_log_pkg::CLASS_POS_INF;
        end else begin
            in_class = fp_log_pkg::CLASS_NORMAL;
        end
    end

    // flushed inputs look up entry 0 in both tables
    assign exp_index = in_exp;   // exponent field is 0 for them already
    assign man_index = (in_class == fp_log_pkg::CLASS_ZERO) ? '0
                     : in_man[fp_log_pkg::MAN_INDEX_LSB +: LW];

    exponent_log_lut exponent_log_lut_inst (
        .exp_field (exp_index),
        .log_value (exp_log)
    );

    mantissa_log_lut mantissa_log_lut_inst (
        .man_index (man_index),
        .log_value (man_log)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_class   <= in_class;
        s1_exp_log <= exp_log;
        s1_man_log <= man_log;
        cls_d1     <= s1_class;
        cls_d2     <= cls_d1;   // lines up with add_sum
    end

    fp16_add fp16_add_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (s1_valid),
        .a         (s1_exp_log),
        .b         (s1_man_log),
        .valid_out (add_valid),
        .sum       (add_sum)
    );

    always_comb begin
        case (cls_d2)
            fp_log_pkg::CLASS_NAN,
            fp_log_pkg::CLASS_NEGATIVE: out_next = fp_log_pkg::FP_QNAN;
            fp_log_pkg::CLASS_POS_INF:  out_next = fp_log_pkg::FP_POS_INF;
            fp_log_pkg::CLASS_ZERO:     out_next = fp_log_pkg::FP_NEG_INF;
            default:                    out_next = add_sum;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= add_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= out_next;
    end

    // registered three edges after the sampling edge, seen one sample later
    out_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 4))
        else $error("fp16_log: out_valid does not track in_valid");

    // class taken at the input has to meet its own sample at the override
    nan_on_invalid: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && (in_class == fp_log_pkg::CLASS_NAN
                     || in_class == fp_log_pkg::CLASS_NEGATIVE)
        |-> ##4 out_data[fp_log_pkg::EXP_LSB +: EW] == fp_log_pkg::EXP_MAX
                && out_data[MW-1:0] != '0)
        else $error("fp16_log: invalid input did not give nan");

endmodule

// File: tb/fp16_log_ref.svh
`ifndef FP16_LOG_REF_SVH
`define FP16_LOG_REF_SVH

// expected ln(x) built from the table rules, all in real arithmetic

function automatic real pow2(input int n);
    real p;
    p = 1.0;
    for (int k = 0; k < n; k++) p = p * 2.0;
    for (int k = 0; k > n; k--) p = p / 2.0;
    return p;
endfunction

function automatic real half_to_real(input logic [fp_log_pkg::FP_WIDTH-1:0] h);
    int  e;
    int  m;
    real v;
    e = h[14:10];
    m = h[9:0];
    if (e == 0) return 0.0;   // subnormals flushed
    v = (1.0 + m / 1024.0) * pow2(e - 15);
    return h[15] ? -v : v;
endfunction

// round to nearest even, subnormal results flush to signed zero
function automatic logic [fp_log_pkg::FP_WIDTH-1:0] real_to_half(input real r);
    logic sign;
    real  a;
    real  frac;
    int   e;
    int   fi;
    int   biased;
    if (r == 0.0) return 16'h0000;
    sign = (r < 0.0);
    a    = sign ? -r : r;
    e    = 0;
    while (a >= 2.0) begin
        a = a / 2.0;
        e++;
    end
    while (a < 1.0) begin
        a = a * 2.0;
        e--;
    end
    frac = (a - 1.0) * 1024.0;
    fi   = $rtoi(frac);
    frac = frac - fi;   // leftover below the last mantissa bit
    if (frac > 0.5 || (frac == 0.5 && fi[0])) fi++;
    if (fi == 1024) begin
        fi = 0;
        e++;
    end
    biased = e + 15;
    if (biased >= 31) return {sign, 5'h1F, 10'h000};
    if (biased <= 0) return {sign, 15'h0000};
    return {sign, biased[4:0], fi[9:0]};
endfunction

function automatic fp_log_pkg::fp_class_e classify_input(input logic [15:0] x);
    if (x[14:10] == 5'd0) return fp_log_pkg::CLASS_ZERO;   // either sign
    if (x[14:10] == 5'd31 && x[9:0] != 10'd0) return fp_log_pkg::CLASS_NAN;
    if (x[15]) return fp_log_pkg::CLASS_NEGATIVE;
    if (x[14:10] == 5'd31) return fp_log_pkg::CLASS_POS_INF;
    return fp_log_pkg::CLASS_NORMAL;
endfunction

function automatic logic [fp_log_pkg::FP_WIDTH-1:0] expected_log(input logic [15:0] x);
    int  e;
    int  i;
    real exp_part;
    real man_part;
    case (classify_input(x))
        fp_log_pkg::CLASS_ZERO:    return fp_log_pkg::FP_NEG_INF;
        fp_log_pkg::CLASS_POS_INF: return fp_log_pkg::FP_POS_INF;
        fp_log_pkg::CLASS_NORMAL: begin
            e = x[14:10];
            i = x[9:5];
            exp_part = half_to_real(real_to_half((e - 15) * $ln(2.0)));
            man_part = half_to_real(real_to_half($ln(1.0 + i / 32.0)));
            return real_to_half(exp_part + man_part);   // one rounding of the exact sum
        end
        default: return fp_log_pkg::FP_QNAN;
    endcase
endfunction

`endif

// File: tb/tb_fp16_log.sv
`timescale 1ns/1ps

module tb_fp16_log;

    localparam int FW            = fp_log_pkg::FP_WIDTH;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 16;
    localparam int LATENCY       = 3;
    localparam int POW_COUNT     = 30;
    localparam int SPECIAL_COUNT = 14;
    localparam int RANDOM_COUNT  = 2000;
    localparam int STREAM_COUNT  = 400;
    localparam int TOTAL_SAMPLES = POW_COUNT + SPECIAL_COUNT + RANDOM_COUNT + STREAM_COUNT;
    localparam int WATCHDOG_CYCLES = (TOTAL_SAMPLES + LATENCY + RESET_CYCLES) * 4;

    logic          clk = 1'b0;
    logic          arst_n;
    logic          in_valid;
    logic [FW-1:0] in_data;
    logic          out_valid;
    logic [FW-1:0] out_data;

    logic [31:0]   lfsr_state;
    int            cycle_count = 0;
    int            checks_failed = 0;
    int            issued;
    int            seen = 0;
    string         test_name = "reset";

    // scoreboard, one entry per accepted sample
    logic [FW-1:0] expect_queue[$];
    int            issue_queue[$];
    logic [2:0]    class_queue[$];
    logic [FW-1:0] popped_value;
    int            popped_cycle;
    fp_log_pkg::fp_class_e popped_class;

    logic [31:0]   bits;
    logic [31:0]   gap_bits;
    logic [FW-1:0] sample;

    `include "fp16_log_ref.svh"

    fp16_log fp16_log_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        checks_failed++;
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [FW-1:0] expected,
                               input logic [FW-1:0] actual);
        if (actual !== expected)
            fail_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
            fail_run($sformatf("FAILED %s output count expected %0d actual %0d",
                               name, expected, actual));
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected)
            fail_run($sformatf("FAILED %s latency expected %0d actual %0d",
                               name, expected, actual));
    endtask

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] draw_bits(input int n);
        logic        lsb;
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lsb = lfsr_state[0];
            v = {v[30:0], lsb};
            lfsr_state = lfsr_state >> 1;
            if (lsb) lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return v;
    endfunction

    task automatic random_normal(output logic [FW-1:0] x);
        logic [31:0] e;
        logic [31:0] m;
        e = draw_bits(5);
        while (e[4:0] == 5'd0 || e[4:0] == 5'd31) e = draw_bits(5);   // keep it normal
        m = draw_bits(10);
        x = {1'b0, e[4:0], m[9:0]};
    endtask

    // called 1 ns after a rising edge, sampled at the next one
    task automatic drive_sample(input logic [FW-1:0] x);
        in_valid = 1'b1;
        in_data  = x;
        expect_queue.push_back(expected_log(x));
        issue_queue.push_back(cycle_count + 1);
        class_queue.push_back(classify_input(x));
        issued++;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        issued = 0;
        seen = 0;
    endtask

    // last sample is registered three edges after it was taken
    task automatic finish_test();
        in_valid = 1'b0;
        idle_cycles(LATENCY + 1);
        check_count(test_name, issued, seen);
    endtask

    function automatic logic [FW-1:0] special_input(input int i);
        case (i)
            0:  return 16'h0000;   // +0
            1:  return 16'h8000;   // -0
            2:  return 16'h0001;
            3:  return 16'h03FF;
            4:  return 16'h8200;   // negative subnormal
            5:  return 16'h7C00;
            6:  return 16'hFC00;
            7:  return 16'h7E00;
            8:  return 16'h7C01;   // signalling nan
            9:  return 16'hFE00;
            10: return 16'hFFFF;
            11: return 16'hBC00;   // -1.0
            12: return 16'hC500;
            default: return 16'h8400;
        endcase
    endfunction

    // outputs are stable by the falling edge
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (expect_queue.size() == 0)
                fail_run($sformatf("out_valid pulsed with no input pending in %s", test_name));
            popped_value = expect_queue.pop_front();
            popped_cycle = issue_queue.pop_front();
            popped_class = fp_log_pkg::fp_class_e'(class_queue.pop_front());
            check_value($sformatf("%s/%s", test_name, popped_class.name()),
                        popped_value, out_data);
            check_latency(test_name, LATENCY, cycle_count - popped_cycle);
            seen++;
        end else if (out_valid !== 1'b0) begin
            fail_run($sformatf("out_valid is unknown in %s", test_name));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before all tests finished");
    end

    initial begin
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        lfsr_state = 32'd73996;
        issued     = 0;

        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle_cycles(8);   // still nothing may come out

        start_test("powers_of_two");
        for (int e = 1; e <= POW_COUNT; e++) drive_sample({1'b0, 5'(e), 10'h000});
        finish_test();

        start_test("special_inputs");
        for (int i = 0; i < SPECIAL_COUNT; i++) drive_sample(special_input(i));
        finish_test();

        start_test("random_normals");
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            random_normal(sample);
            drive_sample(sample);
        end
        finish_test();

        // any bit pattern, gaps of 0, 0, 1 or 2 cycles
        start_test("streaming");
        for (int i = 0; i < STREAM_COUNT; i++) begin
            bits = draw_bits(FW);
            drive_sample(bits[FW-1:0]);
            gap_bits = draw_bits(2);
            if (gap_bits[1:0] >= 2'd2) idle_cycles(int'(gap_bits[1:0]) - 1);
        end
        finish_test();

        if (checks_failed == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("one or more checks failed");
        end
    end

endmodule

// File: fp16_log.f
+incdir+tb
common/fp_log_pkg.sv
hw/exponent_log_lut.sv
hw/mantissa_log_lut.sv
fp16_adder/fp16_add.sv
hw/fp16_log.sv
tb/tb_fp16_log.sv

// File: Bender.yml
package:
  name: fp16_log

sources:
  - common/fp_log_pkg.sv
  - hw/exponent_log_lut.sv
  - hw/mantissa_log_lut.sv
  - fp16_adder/fp16_add.sv
  - hw/fp16_log.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_fp16_log.sv
